//--- verif/cpu_trace.txt
// Execution core trace, 32-bit hex words for $readmemh
// @00 header: program words, data words, expected stores, halt opcode
// @10 program words, @C0 initial data {addr,data}, @E0 expected stores {addr,data}
@00
0000004E 00000002 00000014 000000FF
@10
02011234 02020F0F 02030004 01040100 10040200 06040100 11040300 06040101
12040200 06040102 13040100 06040103 14040200 06040104 15040300 06040105
16040300 06040106 02080E0E 02090A0A 020A8000 020B0001 020D00EC 170B0A00
24006C00 06080200 21007000 06090200 170B0A00 25008000 06080201 21008400
06090201 170A0B00 26009400 06080202 21009800 06090202 170A0B00 2700A800
06080203 2100AC00 06090203 180B0A00 2200BC00 06080204 2100C000 06090204
18010200 2300D000 06080205 2100D400 06090205 17020200 010C0200 2200E800
06080206 200D0000 06090206 04050300 06050400 02060301 03070600 06070401
020E0402 05050E00 020103E8 02020007 19010200 06010500 02030000 19020300
06020501 02030010 19020300 06020502 FF000000 06010600
@C0
0300BEEF 03015A5A
@E0
01002143 0101213F 0102010F 0103133F 01041C30 0105C300 01060C30 02000A0A
02010E0E 02020A0A 02030E0E 02040A0A 02050A0A 02060E0E 0400BEEF 04015A5A
0402BEEF 0500008E 0501FFFF 05020FFF

//--- project.f
verilog/core_pkg.sv
verilog/isa_pkg.sv
verilog/reg_file.sv
verilog/alu_flags.sv
verilog/div_unit.sv
verilog/exec_control.sv
verilog/cpu_core.sv
verif/tb_cpu_core.sv

//--- Makefile
# Verilator build and run of the execution core testbench

VERILATOR ?= verilator
TOP       ?= tb_cpu_core
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= Test OK

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

//--- verif/tb_cpu_core.sv
// Testbench for the execution core.
// Loads verif/cpu_trace.txt, serves instructions from its program words
// with random fetch gaps, models data memory with random response
// latency, and checks every store and the final halt status against
// the trace. Run from the project root.

`timescale 1ns/1ps

module tb_cpu_core import core_pkg::*, isa_pkg::*; ();

   // Word offsets of the trace sections
   localparam int TRACE_WORDS     = 256;
   localparam int PROG_BASE       = 'h10;
   localparam int DATA_BASE       = 'hC0;
   localparam int STORE_BASE      = 'hE0;
   localparam int MAX_LAT         = 3;
   localparam int CYCLES_PER_WORD = 40;
   localparam int QUIET_CYCLES    = 20;

   logic         clk;
   logic         reset;
   logic         instr_valid;
   instr_u       instr;
   addr_t        instr_ptr;
   mem_req_t     mem_req;
   mem_rsp_t     mem_rsp;
   core_status_t status;

   logic [31:0] trace [TRACE_WORDS];
   word_t       dmem [65536];
   word_t       read_data;
   logic [7:0]  halt_op;
   logic        trace_loaded;
   int          n_prog, n_data, n_store;
   int          store_count, gap, rsp_wait;
   integer      seed;

   cpu_core DUT (
      .clk         (clk),
      .reset       (reset),
      .instr_valid (instr_valid),
      .instr       (instr),
      .instr_ptr   (instr_ptr),
      .mem_req     (mem_req),
      .mem_rsp     (mem_rsp),
      .status      (status)
   );

   initial clk = 1'b0;
   always #2 clk = ~clk;

   task automatic report_failure(input string msg);
      $display("%s", msg);
      $display("Test FAILED");
      $fatal(1, "simulation stopped on a failed check");
   endtask

   task automatic load_trace();
      int a;
      for (a = 0; a < TRACE_WORDS; a++) trace[a] = '0;
      $readmemh("verif/cpu_trace.txt", trace);
      n_prog  = trace[0];
      n_data  = trace[1];
      n_store = trace[2];
      halt_op = trace[3][7:0];
      // Background pattern, then the initial words from the trace
      for (a = 0; a < 65536; a++) dmem[a] = word_t'(a) ^ 16'hC35A;
      for (a = 0; a < n_data; a++) dmem[trace[DATA_BASE + a][31:16]] = trace[DATA_BASE + a][15:0];
      trace_loaded = 1'b1;
   endtask

   task automatic check_store(input addr_t addr, input word_t data);
      logic [31:0] expected;
      assert (!status.halted) else
         report_failure($sformatf("store to address %h after the core halted", addr));
      assert (store_count < n_store) else
         report_failure($sformatf("unexpected store to address %h, the trace lists only %0d",
                                  addr, n_store));
      expected = trace[STORE_BASE + store_count];
      assert (addr == expected[31:16]) else
         report_failure($sformatf("MISMATCH mem_req.addr (store %0d): got %h expected %h",
                                  store_count, addr, expected[31:16]));
      assert (data == expected[15:0]) else
         report_failure($sformatf("MISMATCH mem_req.wdata (store %0d): got %h expected %h",
                                  store_count, data, expected[15:0]));
      store_count++;
   endtask

   // Instruction source, 0 to 2 idle cycles after each valid beat
   task automatic drive_fetch();
      int idx;
      idx = instr_ptr[15:2];
      if (instr_valid) gap = $unsigned($random(seed)) % 3;
      if (gap > 0) begin
         instr_valid = 1'b0;
         gap--;
      end else begin
         instr_valid = 1'b1;
      end
      instr = (idx < n_prog) ? trace[PROG_BASE + idx] : 32'h0;
   endtask

   // Data memory, done pulse 1 to 3 cycles after the request
   task automatic serve_memory();
      mem_rsp.done = 1'b0;
      if (mem_req.wr_en) begin
         check_store(mem_req.addr, mem_req.wdata);
         dmem[mem_req.addr] = mem_req.wdata;
         rsp_wait = 1 + $unsigned($random(seed)) % 3;
      end else if (mem_req.rd_en) begin
         read_data = dmem[mem_req.addr];
         rsp_wait  = 1 + $unsigned($random(seed)) % 3;
      end else if (rsp_wait > 0) begin
         rsp_wait--;
         if (rsp_wait == 0) begin
            mem_rsp.done  = 1'b1;
            mem_rsp.rdata = read_data;
         end
      end
   endtask

   task automatic drive_inputs();
      drive_fetch();
      serve_memory();
   endtask

   initial begin
      seed         = 32'h19b8;
      reset        = 1'b1;
      instr_valid  = 1'b0;
      instr        = '0;
      mem_rsp      = '0;
      read_data    = '0;
      store_count  = 0;
      gap          = 0;
      rsp_wait     = 0;
      trace_loaded = 1'b0;
      load_trace();
      repeat (3) @(negedge clk);
      reset = 1'b0;
      drive_inputs();
      while (!status.halted) begin
         @(negedge clk);
         drive_inputs();
      end
      // Keep serving, a halted core must not store again
      repeat (QUIET_CYCLES) begin
         @(negedge clk);
         drive_inputs();
      end
      assert (status.bad_opcode == halt_op) else
         report_failure($sformatf("MISMATCH status.bad_opcode: got %h expected %h",
                                  status.bad_opcode, halt_op));
      assert (store_count == n_store) else
         report_failure($sformatf("core made %0d stores but the trace expects %0d",
                                  store_count, n_store));
      $display("Test OK");
      $finish;
   end

   // Watchdog, scaled by program length and worst memory latency
   initial begin : watchdog
      int limit;
      wait (trace_loaded);
      limit = n_prog * CYCLES_PER_WORD * MAX_LAT;
      repeat (limit) @(posedge clk);
      report_failure($sformatf("timeout: the core never halted within %0d cycles", limit));
   end

endmodule

//--- verilog/cpu_core.sv
// Top level of the 16-bit execution core.
// Connects the control FSM, register file, ALU and divider. The core
// fetches from instr_ptr and talks to data memory through mem_req and
// mem_rsp. RESET_PC and WIDTH are set here and passed down.

`timescale 1ns/1ps

module cpu_core import core_pkg::*, isa_pkg::*; #(
   parameter addr_t RESET_PC = '0,
   parameter int    WIDTH    = WORD_BITS
) (
   input  logic         clk,
   input  logic         reset,
   input  logic         instr_valid,
   input  instr_u       instr,
   output addr_t        instr_ptr,
   output mem_req_t     mem_req,
   input  mem_rsp_t     mem_rsp,
   output core_status_t status
);

   word_t    dest_word, src_word, alu_result, wr_data;
   word_t    quotient, dividend, divisor;
   reg_idx_t dest_idx, src_idx, wr_idx;
   logic     wr_en, alu_update, div_start, div_done;
   alu_op_e  alu_op;
   flags_t   flags;

   exec_control #(.RESET_PC(RESET_PC)) u_exec_control (
      .clk         (clk),
      .reset       (reset),
      .instr_valid (instr_valid),
      .instr       (instr),
      .dest_word   (dest_word),
      .src_word    (src_word),
      .alu_result  (alu_result),
      .flags       (flags),
      .div_done    (div_done),
      .quotient    (quotient),
      .mem_rsp     (mem_rsp),
      .instr_ptr   (instr_ptr),
      .dest_idx    (dest_idx),
      .src_idx     (src_idx),
      .wr_en       (wr_en),
      .wr_idx      (wr_idx),
      .wr_data     (wr_data),
      .alu_op      (alu_op),
      .alu_update  (alu_update),
      .div_start   (div_start),
      .dividend    (dividend),
      .divisor     (divisor),
      .mem_req     (mem_req),
      .status      (status)
   );

   reg_file u_reg_file (
      .clk      (clk),
      .reset    (reset),
      .rd_idx_a (dest_idx),
      .rd_idx_b (src_idx),
      .wr_en    (wr_en),
      .wr_idx   (wr_idx),
      .wr_data  (wr_data),
      .rd_a     (dest_word),
      .rd_b     (src_word)
   );

   alu_flags u_alu_flags (
      .clk    (clk),
      .reset  (reset),
      .op     (alu_op),
      .a      (dest_word),
      .b      (src_word),
      .update (alu_update),
      .result (alu_result),
      .flags  (flags)
   );

   div_unit #(.WIDTH(WIDTH)) u_div_unit (
      .clk      (clk),
      .reset    (reset),
      .start    (div_start),
      .dividend (dividend),
      .divisor  (divisor),
      .quotient (quotient),
      .done     (div_done)
   );

endmodule

//--- verilog/exec_control.sv
// Control FSM of the execution core.
// Decodes one instruction per valid cycle, steps or loads the instruction
// pointer, and drives the register write port. Loads, stores and DIV
// leave the executing state until memory or the divider answers.
// An unknown opcode halts the core until reset.

`timescale 1ns/1ps

module exec_control import core_pkg::*, isa_pkg::*; #(
   parameter addr_t RESET_PC = '0
) (
   input  logic         clk,
   input  logic         reset,
   input  logic         instr_valid,
   input  instr_u       instr,
   input  word_t        dest_word,
   input  word_t        src_word,
   input  word_t        alu_result,
   input  flags_t       flags,
   input  logic         div_done,
   input  word_t        quotient,
   input  mem_rsp_t     mem_rsp,
   output addr_t        instr_ptr,
   output reg_idx_t     dest_idx,
   output reg_idx_t     src_idx,
   output logic         wr_en,
   output reg_idx_t     wr_idx,
   output word_t        wr_data,
   output alu_op_e      alu_op,
   output logic         alu_update,
   output logic         div_start,
   output word_t        dividend,
   output word_t        divisor,
   output mem_req_t     mem_req,
   output core_status_t status
);

   typedef enum logic [1:0] {S_EXEC, S_RD_WAIT, S_WR_WAIT, S_DIV_WAIT} state_e;

   state_e   state;
   reg_idx_t load_reg;
   opcode_e  opcode;
   word_t    imm;
   addr_t    jump_target;
   logic     exec_now, jump_taken, invalid;

   assign opcode   = instr.r_form.opcode;
   assign imm      = instr.i_form.imm;
   assign dest_idx = instr.r_form.dst;
   assign src_idx  = instr.r_form.src;

   // One instruction per valid cycle while executing and not halted
   assign exec_now   = (state == S_EXEC) && instr_valid && !status.halted;
   assign alu_update = exec_now;

   // Opcode to ALU op, jump condition from the current flags
   always_comb begin
      alu_op      = ALU_NONE;
      jump_taken  = 1'b0;
      jump_target = {instr.i_form.target_hi, instr.i_form.imm[15:8]};
      invalid     = 1'b0;
      case (opcode)
         OP_NOP, OP_MOVI, OP_LOAD, OP_LOADI, OP_STOR, OP_STORI, OP_DIV:
            alu_op = ALU_NONE;
         OP_MOV:  alu_op = ALU_PASS_B;
         OP_ADD:  alu_op = ALU_ADD;
         OP_SUB:  alu_op = ALU_SUB;
         OP_AND:  alu_op = ALU_AND;
         OP_OR:   alu_op = ALU_OR;
         OP_XOR:  alu_op = ALU_XOR;
         OP_SHL:  alu_op = ALU_SHL;
         OP_SHRL: alu_op = ALU_SHRL;
         OP_CMP:  alu_op = ALU_CMP;
         OP_TST:  alu_op = ALU_TST;
         OP_JMP: begin
            jump_taken  = 1'b1;
            jump_target = dest_word;
         end
         OP_JMPI: jump_taken = 1'b1;
         OP_JEQ:  jump_taken = flags.zero;
         OP_JNE:  jump_taken = !flags.zero;
         OP_JB:   jump_taken = flags.carry;
         OP_JAE:  jump_taken = !flags.carry;
         OP_JL:   jump_taken = flags.sign != flags.overflow;
         OP_JGE:  jump_taken = flags.sign == flags.overflow;
         default: invalid = 1'b1;
      endcase
   end

   // Write-back source: ALU, immediate, memory or quotient
   always_comb begin
      wr_en   = 1'b0;
      wr_idx  = dest_idx;
      wr_data = alu_result;
      case (state)
         S_EXEC: begin
            if (exec_now) begin
               case (opcode)
                  OP_MOV, OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SHL, OP_SHRL:
                     wr_en = 1'b1;
                  OP_MOVI: begin
                     wr_en   = 1'b1;
                     wr_data = imm;
                  end
                  default: wr_en = 1'b0;
               endcase
            end
         end
         S_RD_WAIT: begin
            wr_en   = mem_rsp.done;
            wr_idx  = load_reg;
            wr_data = mem_rsp.rdata;
         end
         S_DIV_WAIT: begin
            wr_en   = div_done;
            wr_idx  = load_reg;
            wr_data = quotient;
         end
         default: wr_en = 1'b0;
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         state     <= S_EXEC;
         instr_ptr <= RESET_PC;
         mem_req   <= '0;
         div_start <= 1'b0;
         status    <= '0;
      end else begin
         // Request and start are single-cycle pulses
         mem_req.rd_en <= 1'b0;
         mem_req.wr_en <= 1'b0;
         div_start     <= 1'b0;
         case (state)
            S_EXEC: begin
               if (exec_now) begin
                  if (invalid) begin
                     status.halted     <= 1'b1;
                     status.bad_opcode <= opcode;
                  end else if (jump_taken) begin
                     instr_ptr <= jump_target;
                  end else begin
                     instr_ptr <= instr_ptr + INSTR_BYTES;
                  end
                  case (opcode)
                     OP_LOAD, OP_LOADI: begin
                        mem_req.rd_en <= 1'b1;
                        mem_req.addr  <= (opcode == OP_LOAD) ? src_word : imm;
                        load_reg      <= dest_idx;
                        state         <= S_RD_WAIT;
                     end
                     // STOR stores DEST at the address held in SRC
                     OP_STOR, OP_STORI: begin
                        mem_req.wr_en <= 1'b1;
                        mem_req.addr  <= (opcode == OP_STOR) ? src_word : imm;
                        mem_req.wdata <= dest_word;
                        state         <= S_WR_WAIT;
                     end
                     OP_DIV: begin
                        div_start <= 1'b1;
                        dividend  <= dest_word;
                        divisor   <= src_word;
                        load_reg  <= dest_idx;
                        state     <= S_DIV_WAIT;
                     end
                     default: state <= S_EXEC;
                  endcase
               end
            end
            S_RD_WAIT:  if (mem_rsp.done) state <= S_EXEC;
            S_WR_WAIT:  if (mem_rsp.done) state <= S_EXEC;
            S_DIV_WAIT: if (div_done) state <= S_EXEC;
            default:    state <= S_EXEC;
         endcase
      end
   end

endmodule

//--- verilog/div_unit.sv
// Restoring divider, one quotient bit per cycle.
// Pulse start with the operands; done pulses WIDTH cycles later with
// the quotient. A zero divisor gives a quotient of all ones.

`timescale 1ns/1ps

module div_unit import core_pkg::*; #(
   parameter int WIDTH = WORD_BITS
) (
   input  logic             clk,
   input  logic             reset,
   input  logic             start,
   input  logic [WIDTH-1:0] dividend,
   input  logic [WIDTH-1:0] divisor,
   output logic [WIDTH-1:0] quotient,
   output logic             done
);

   localparam int CNT_BITS = $clog2(WIDTH + 1);

   logic [WIDTH-1:0]    rem, dvs;
   logic [WIDTH-1:0]    step_rem, step_quo, step_dvs;
   logic [WIDTH:0]      shifted, trial;
   logic [CNT_BITS-1:0] count;
   logic                busy;

   // First step runs on the start edge, straight from the operands
   assign step_rem = start ? '0 : rem;
   assign step_quo = start ? dividend : quotient;
   assign step_dvs = start ? divisor : dvs;
   assign shifted  = {step_rem, step_quo[WIDTH-1]};
   assign trial    = shifted - {1'b0, step_dvs};

   always_ff @(posedge clk) begin
      if (start || busy) begin
         if (trial[WIDTH]) begin
            // Restore: keep the shifted remainder, quotient bit 0
            rem      <= shifted[WIDTH-1:0];
            quotient <= {step_quo[WIDTH-2:0], 1'b0};
         end else begin
            rem      <= trial[WIDTH-1:0];
            quotient <= {step_quo[WIDTH-2:0], 1'b1};
         end
      end
      if (start) begin
         dvs <= divisor;
      end
   end

   // Iteration counter, counts the steps still to go
   always_ff @(posedge clk) begin
      if (reset) begin
         busy  <= 1'b0;
         done  <= 1'b0;
         count <= '0;
      end else begin
         done <= 1'b0;
         if (start) begin
            busy  <= (WIDTH > 1);
            done  <= (WIDTH == 1);
            count <= CNT_BITS'(WIDTH - 1);
         end else if (busy) begin
            count <= count - 1'b1;
            if (count == 1) begin
               busy <= 1'b0;
               done <= 1'b1;
            end
         end
      end
   end

endmodule

//--- verilog/alu_flags.sv
// Combinational ALU with the flags register.
// result follows op, a and b in the same cycle. When update is high the
// flags take the new value: ADD, SUB, CMP and TST set them, any other
// op clears them.

`timescale 1ns/1ps

module alu_flags import core_pkg::*; (
   input  logic    clk,
   input  logic    reset,
   input  alu_op_e op,
   input  word_t   a,
   input  word_t   b,
   input  logic    update,
   output word_t   result,
   output flags_t  flags
);

   localparam int MSB = WORD_BITS - 1;

   // One bit wider than a word, top bit is the carry
   logic [WORD_BITS:0] wide;
   flags_t             next_flags;

   always_comb begin
      case (op)
         ALU_PASS_B:        wide = {1'b0, b};
         ALU_ADD:           wide = {1'b0, a} + {1'b0, b};
         ALU_SUB, ALU_CMP:  wide = {1'b0, a} - {1'b0, b};
         ALU_AND, ALU_TST:  wide = {1'b0, a & b};
         ALU_OR:            wide = {1'b0, a | b};
         ALU_XOR:           wide = {1'b0, a ^ b};
         ALU_SHL:           wide = {1'b0, a << b};
         ALU_SHRL:          wide = {1'b0, a >> b};
         default:           wide = '0;
      endcase
   end

   assign result = wide[MSB:0];

   always_comb begin
      next_flags = '0;
      case (op)
         ALU_ADD, ALU_SUB, ALU_CMP, ALU_TST: begin
            next_flags.carry = wide[WORD_BITS];
            next_flags.zero  = (wide[MSB:0] == '0);
            next_flags.sign  = wide[MSB];
         end
         default: next_flags = '0;
      endcase
      // Signed overflow when the result sign disagrees with the operands
      if (op == ALU_ADD) begin
         next_flags.overflow = (a[MSB] & b[MSB] & ~wide[MSB]) |
                               (~a[MSB] & ~b[MSB] & wide[MSB]);
      end else if (op == ALU_SUB || op == ALU_CMP) begin
         next_flags.overflow = (a[MSB] & ~b[MSB] & ~wide[MSB]) |
                               (~a[MSB] & b[MSB] & wide[MSB]);
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         flags <= '0;
      end else if (update) begin
         flags <= next_flags;
      end
   end

endmodule

//--- verilog/reg_file.sv
// Sixteen-word register file.
// Two asynchronous read ports and one synchronous write port.

`timescale 1ns/1ps

module reg_file import core_pkg::*; (
   input  logic     clk,
   input  logic     reset,
   input  reg_idx_t rd_idx_a,
   input  reg_idx_t rd_idx_b,
   input  logic     wr_en,
   input  reg_idx_t wr_idx,
   input  word_t    wr_data,
   output word_t    rd_a,
   output word_t    rd_b
);

   word_t regs [16];

   always_ff @(posedge clk) begin
      if (reset) begin
         regs <= '{default: '0};
      end else if (wr_en) begin
         regs[wr_idx] <= wr_data;
      end
   end

   assign rd_a = regs[rd_idx_a];
   assign rd_b = regs[rd_idx_b];

endmodule

//--- verilog/isa_pkg.sv
// Instruction set of the execution core.
// Opcode values, the two decodings of an instruction word, and the
// instruction pointer step. Import where instructions are decoded.

package isa_pkg;

   // Step of the instruction pointer per instruction, in bytes
   parameter logic [15:0] INSTR_BYTES = 16'd4;

   typedef enum logic [7:0] {
      OP_NOP   = 8'h00, OP_MOV   = 8'h01, OP_MOVI  = 8'h02, OP_LOAD  = 8'h03,
      OP_LOADI = 8'h04, OP_STOR  = 8'h05, OP_STORI = 8'h06,
      OP_ADD   = 8'h10, OP_SUB   = 8'h11, OP_AND   = 8'h12, OP_OR    = 8'h13,
      OP_XOR   = 8'h14, OP_SHL   = 8'h15, OP_SHRL  = 8'h16, OP_CMP   = 8'h17,
      OP_TST   = 8'h18, OP_DIV   = 8'h19,
      OP_JMP   = 8'h20, OP_JMPI  = 8'h21, OP_JEQ   = 8'h22, OP_JNE   = 8'h23,
      OP_JB    = 8'h24, OP_JAE   = 8'h25, OP_JL    = 8'h26, OP_JGE   = 8'h27
   } opcode_e;

   // Register form: OP DEST SRC
   typedef struct packed {
      opcode_e    opcode;
      logic [3:0] unused_hi;
      logic [3:0] dst;
      logic [3:0] unused_mid;
      logic [3:0] src;
      logic [7:0] unused_lo;
   } instr_reg_t;

   // Immediate form. The jump address sits in bits 23:8, so it is
   // target_hi followed by the upper byte of imm
   typedef struct packed {
      opcode_e     opcode;
      logic [7:0]  target_hi;
      logic [15:0] imm;
   } instr_imm_t;

   typedef union packed {
      instr_reg_t r_form;
      instr_imm_t i_form;
   } instr_u;

endpackage

//--- verilog/core_pkg.sv
// Datapath types of the execution core.
// Word and address types, flags, ALU operations and the data memory
// request and response bundles.

package core_pkg;

   parameter int WORD_BITS = 16;

   typedef logic [WORD_BITS-1:0] word_t;
   typedef logic [15:0]          addr_t;
   typedef logic [3:0]           reg_idx_t;

   typedef struct packed {
      logic overflow;
      logic carry;
      logic zero;
      logic sign;
   } flags_t;

   typedef enum logic [3:0] {
      ALU_PASS_B, ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
      ALU_SHL, ALU_SHRL, ALU_CMP, ALU_TST, ALU_NONE
   } alu_op_e;

   // One-cycle rd_en or wr_en pulse, address and data in the same cycle
   typedef struct packed {
      logic  rd_en;
      logic  wr_en;
      addr_t addr;
      word_t wdata;
   } mem_req_t;

   typedef struct packed {
      logic  done;
      word_t rdata;
   } mem_rsp_t;

   typedef struct packed {
      logic       halted;
      logic [7:0] bad_opcode;
   } core_status_t;

endpackage
